//--- hdl/tdc_pkg.sv
// TDC measurement definitions
`default_nettype none

package tdc_pkg;

    // One CLK40 cycle of front-end samples
    typedef logic [15:0] sample_word_t;   // MSB is the earliest sample

    // High samples found in one word
    typedef logic [4:0] ones_cnt_t;

    // Pulse width in samples
    typedef logic [11:0] tdc_width_t;     // Wraps modulo 4096

    // Event number carried in each record
    typedef logic [15:0] event_cnt_t;     // Wraps

    // Records refused by a full FIFO
    typedef logic [7:0] lost_cnt_t;       // Saturates at 255

    // Record identifier in the top nibble
    localparam logic [3:0] DATA_IDENTIFIER = 4'b0100;

    // Event FIFO geometry
    localparam int FIFO_DEPTH = 8;        // Power of two only
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // Samples per word for the ones counter
    localparam int WORD_BITS = $bits(sample_word_t);

    // Output record of 32 bits
    typedef struct packed {
        logic [3:0] id;                   // DATA_IDENTIFIER
        event_cnt_t evt;                  // Event number
        tdc_width_t width;                // Measured width
    } tdc_record_t;

endpackage

`default_nettype wire

//--- hdl/wb_pkg.sv
// Wishbone bus and register map
`default_nettype none

package wb_pkg;

    // Register address and data
    typedef logic [1:0] wb_adr_t;
    typedef logic [7:0] wb_dat_t;

    // Master to slave request of 13 bits
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    // Slave to master response of 9 bits
    typedef struct packed {
        logic ack;
        wb_dat_t dat;
    } wb_rsp_t;

    // Configuration register with en in bit 0
    typedef struct packed {
        logic en_arm;                     // Wait for arm before measuring
        logic en;                         // Channel enable
    } tdc_cfg_t;

    // Register map
    localparam wb_adr_t REG_SOFT_RST = 2'd0;  // Write strobes the core reset
    localparam wb_adr_t REG_CONFIG = 2'd1;    // en and en_arm
    localparam wb_adr_t REG_LOST = 2'd2;      // Read only lost record count

endpackage

`default_nettype wire

//--- hdl/tdc_regs.sv
// TDC register slave
`timescale 1ns/1ps
`default_nettype none

module tdc_regs (
    input  wire logic             CLK40,
    input  wire logic             RST_SYNC,
    input  wire wb_pkg::wb_req_t  wb_i,
    output wb_pkg::wb_rsp_t       wb_o,
    output wb_pkg::tdc_cfg_t      cfg,
    input  wire tdc_pkg::lost_cnt_t lost,
    output logic                  core_rst
);

    import wb_pkg::*;

    logic req;
    logic take;
    logic ack_q;
    logic soft_rst_q;
    tdc_cfg_t cfg_q;
    wb_dat_t rd_dat_q;

    assign req = wb_i.cyc & wb_i.stb;
    assign take = req & ~ack_q;           // Second cycle of a request only acks

    // Ack, configuration and soft reset strobe
    always_ff @(posedge CLK40) begin
        if (RST_SYNC) begin
            ack_q <= 1'b0;
            soft_rst_q <= 1'b0;
            cfg_q <= '0;
        end else begin
            ack_q <= take;
            soft_rst_q <= take & wb_i.we & (wb_i.adr == REG_SOFT_RST);
            if (take && wb_i.we) begin
                case (wb_i.adr)
                    REG_SOFT_RST: cfg_q <= '0;    // Soft reset drops the config too
                    REG_CONFIG:   cfg_q <= wb_i.dat[$bits(tdc_cfg_t)-1:0];
                    default:      cfg_q <= cfg_q;
                endcase
            end
        end
    end

    // Read data valid with ack
    always_ff @(posedge CLK40) begin
        if (take && !wb_i.we) begin
            case (wb_i.adr)
                REG_CONFIG: rd_dat_q <= wb_dat_t'(cfg_q);
                REG_LOST:   rd_dat_q <= lost;
                default:    rd_dat_q <= '0;       // Soft reset and address 3
            endcase
        end
    end

    assign wb_o = '{ack: ack_q, dat: rd_dat_q};
    assign cfg = cfg_q;

    // Core blocks see either reset source
    assign core_rst = RST_SYNC | soft_rst_q;

endmodule

`default_nettype wire

//--- hdl/tdc_pulse_fsm.sv
// Pulse detection state machine
`timescale 1ns/1ps
`default_nettype none

module tdc_pulse_fsm (
    input  wire logic                CLK40,
    input  wire logic                core_rst,
    input  wire tdc_pkg::sample_word_t sample,
    input  wire logic                arm_tdc,
    input  wire wb_pkg::tdc_cfg_t    cfg,
    output tdc_pkg::sample_word_t    sample_q,
    output logic                     start,
    output logic                     finish,
    output logic                     tdc_out
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARMED,
        ST_COUNT
    } state_t;

    state_t state_q;
    state_t state_d;
    logic [1:0] arm_sync_q;               // Two-flop synchronizer
    logic arm_s;
    logic one;
    logic zero;

    always_ff @(posedge CLK40) begin
        if (core_rst) begin
            sample_q <= '0;
            arm_sync_q <= '0;
            state_q <= ST_IDLE;
        end else begin
            sample_q <= sample;
            arm_sync_q <= {arm_sync_q[0], arm_tdc};
            state_q <= state_d;
        end
    end

    assign arm_s = arm_sync_q[1];

    // Word contents
    assign one = |sample_q;               // Some sample high
    assign zero = ~&sample_q;             // Some sample low

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cfg.en && !cfg.en_arm && one)
                    state_d = ST_COUNT;
                else if (cfg.en && cfg.en_arm && arm_s)
                    state_d = ST_ARMED;
            end
            ST_ARMED: begin
                if (one)
                    state_d = ST_COUNT;
                else if (!cfg.en)
                    state_d = ST_IDLE;
            end
            ST_COUNT: begin
                if (zero || !cfg.en)
                    state_d = ST_IDLE;  // Pulse ended or channel disabled
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // Strobes to the accumulator
    assign start = (state_q != ST_COUNT) && (state_d == ST_COUNT);
    assign finish = (state_q == ST_COUNT) && (state_d == ST_IDLE);

    assign tdc_out = |sample_q;

endmodule

`default_nettype wire

//--- hdl/tdc_width_accum.sv
// Pulse width accumulator
`timescale 1ns/1ps
`default_nettype none

module tdc_width_accum (
    input  wire logic                CLK40,
    input  wire logic                core_rst,
    input  wire tdc_pkg::sample_word_t sample_q,
    input  wire logic                start,
    input  wire logic                finish,
    output tdc_pkg::tdc_record_t     record
);

    import tdc_pkg::*;

    ones_cnt_t ones;
    tdc_width_t width_q;
    tdc_width_t width_sum;
    event_cnt_t evt_q;

    // Population count of the current word
    always_comb begin
        ones = '0;
        for (int i = 0; i < WORD_BITS; i++) begin
            ones = ones + ones_cnt_t'(sample_q[i]);
        end
    end

    // Width so far including the current word
    assign width_sum = width_q + tdc_width_t'(ones);

    // Running width restarted on the start word
    always_ff @(posedge CLK40) begin
        if (core_rst) begin
            width_q <= '0;
        end else if (start) begin
            width_q <= tdc_width_t'(ones);
        end else begin
            width_q <= width_sum;         // Stale outside a pulse and reloaded at start
        end
    end

    always_ff @(posedge CLK40) begin
        if (core_rst) begin
            evt_q <= '0;
        end else if (finish) begin
            evt_q <= evt_q + 1'b1;
        end
    end

    // Record for the FIFO written on finish
    assign record = '{id: DATA_IDENTIFIER, evt: evt_q, width: width_sum};

endmodule

`default_nettype wire

//--- hdl/tdc_event_fifo.sv
// Event record FIFO
`timescale 1ns/1ps
`default_nettype none

module tdc_event_fifo (
    input  wire logic                CLK40,
    input  wire logic                core_rst,
    input  wire tdc_pkg::tdc_record_t record,
    input  wire logic                write,
    input  wire logic                fifo_read,
    output logic                     fifo_empty,
    output tdc_pkg::tdc_record_t     fifo_data,
    output tdc_pkg::lost_cnt_t       lost
);

    import tdc_pkg::*;

    tdc_record_t mem [FIFO_DEPTH];
    logic [FIFO_AW:0] wr_ptr_q;           // Extra bit tells full from empty
    logic [FIFO_AW:0] rd_ptr_q;
    logic full;
    logic do_write;
    logic do_read;
    logic empty_q;
    lost_cnt_t lost_q;

    assign full = (wr_ptr_q[FIFO_AW] != rd_ptr_q[FIFO_AW]) &&
                  (wr_ptr_q[FIFO_AW-1:0] == rd_ptr_q[FIFO_AW-1:0]);

    assign do_write = write & ~full;
    assign do_read = fifo_read & ~empty_q;  // Pops while empty are dropped

    always_ff @(posedge CLK40) begin
        if (do_write) begin
            mem[wr_ptr_q[FIFO_AW-1:0]] <= record;
        end
    end

    always_ff @(posedge CLK40) begin
        if (core_rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            empty_q <= 1'b1;
        end else begin
            if (do_write)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_read)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            // Old write pointer delays a new record by one cycle
            empty_q <= (wr_ptr_q == (rd_ptr_q + (FIFO_AW + 1)'(do_read)));
        end
    end

    // Refused records
    always_ff @(posedge CLK40) begin
        if (core_rst) begin
            lost_q <= '0;
        end else if (write && full && !(&lost_q)) begin
            lost_q <= lost_q + 1'b1;
        end
    end

    // Head record as first word fall through
    assign fifo_data = mem[rd_ptr_q[FIFO_AW-1:0]];
    assign fifo_empty = empty_q;
    assign lost = lost_q;

endmodule

`default_nettype wire

//--- hdl/tdc_top.sv
// TDC channel top level
`timescale 1ns/1ps
`default_nettype none

module tdc_top (
    input  wire logic                CLK40,
    input  wire logic                RST_SYNC,
    input  wire tdc_pkg::sample_word_t sample,
    input  wire logic                arm_tdc,
    output logic                     tdc_out,
    input  wire wb_pkg::wb_req_t     wb_i,
    output wb_pkg::wb_rsp_t          wb_o,
    input  wire logic                fifo_read,
    output logic                     fifo_empty,
    output tdc_pkg::tdc_record_t     fifo_data
);

    import tdc_pkg::*;
    import wb_pkg::*;

    logic core_rst;
    tdc_cfg_t cfg;
    lost_cnt_t lost;
    sample_word_t sample_q;
    logic start;
    logic finish;
    tdc_record_t record;

    tdc_regs u_regs (
        .CLK40    (CLK40),
        .RST_SYNC (RST_SYNC),
        .wb_i     (wb_i),
        .wb_o     (wb_o),
        .cfg      (cfg),
        .lost     (lost),
        .core_rst (core_rst)
    );

    tdc_pulse_fsm u_pulse_fsm (
        .CLK40    (CLK40),
        .core_rst (core_rst),
        .sample   (sample),
        .arm_tdc  (arm_tdc),
        .cfg      (cfg),
        .sample_q (sample_q),
        .start    (start),
        .finish   (finish),
        .tdc_out  (tdc_out)
    );

    tdc_width_accum u_width_accum (
        .CLK40    (CLK40),
        .core_rst (core_rst),
        .sample_q (sample_q),
        .start    (start),
        .finish   (finish),
        .record   (record)
    );

    tdc_event_fifo u_event_fifo (
        .CLK40      (CLK40),
        .core_rst   (core_rst),
        .record     (record),
        .write      (finish),        // One record per finished pulse
        .fifo_read  (fifo_read),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data),
        .lost       (lost)
    );

endmodule

`default_nettype wire

//--- tb/tb_clkgen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic CLK40,
    output logic RST_SYNC
);

    initial begin
        CLK40 = 1'b0;
        forever #2 CLK40 = ~CLK40;        // 4 ns period
    end

    initial begin
        RST_SYNC = 1'b1;
        repeat (8) @(posedge CLK40);
        RST_SYNC <= 1'b0;                 // Released at the eighth rising edge
    end

endmodule

`default_nettype wire

//--- tb/tb_tdc.sv
// TDC channel testbench
`timescale 1ns/1ps
`default_nettype none

module tb_tdc;

    import tdc_pkg::*;
    import wb_pkg::*;

    typedef enum logic [2:0] {K_WRITE, K_READ, K_WORD, K_ARM, K_POP} kind_t;
    typedef struct packed {
        kind_t kind;
        logic [31:0] op;                  // K_WORD bit 16 picks an LFSR word
        logic [31:0] exp;
    } step_t;
    typedef enum logic [1:0] {M_IDLE, M_ARMED, M_COUNT} mstate_t;

    logic CLK40;
    logic RST_SYNC;
    sample_word_t sample;
    logic arm_tdc;
    logic tdc_out;
    wb_req_t wb_i;
    wb_rsp_t wb_o;
    logic fifo_read;
    logic fifo_empty;
    tdc_record_t fifo_data;

    // Values to drive at the next edge and what the DUT holds now
    sample_word_t n_sample;
    sample_word_t d_sample;
    logic n_arm;
    logic d_arm;
    logic n_read;
    logic d_read;
    wb_req_t n_req;
    wb_req_t d_req;

    // Reference model state
    sample_word_t m_sq;
    logic [1:0] m_arm;
    mstate_t m_state;
    tdc_width_t m_width;
    event_cnt_t m_evt;
    logic m_ack;
    logic m_soft;
    tdc_cfg_t m_cfg;
    lost_cnt_t m_lost;
    tdc_record_t m_fifo[$];

    step_t steps[$];
    logic [15:0] lfsr = 16'd9;

    tb_clkgen u_clkgen (.CLK40(CLK40), .RST_SYNC(RST_SYNC));

    tdc_top dut (
        .CLK40(CLK40), .RST_SYNC(RST_SYNC), .sample(sample), .arm_tdc(arm_tdc),
        .tdc_out(tdc_out), .wb_i(wb_i), .wb_o(wb_o), .fifo_read(fifo_read),
        .fifo_empty(fifo_empty), .fifo_data(fifo_data)
    );

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // Taps 16 14 13 11
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic ones_cnt_t count_ones(sample_word_t w);
        ones_cnt_t n;
        n = '0;
        for (int i = 0; i < $bits(sample_word_t); i++) begin
            n += w[i];
        end
        return n;
    endfunction

    task automatic report_failure(string what);
        $display("%s at %0t", what, $time);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_record(string name, tdc_record_t got, tdc_record_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_reg(string name, wb_dat_t got, wb_dat_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Model update with the inputs the DUT sampled at this edge
    task automatic model_edge();
        logic core_rst;
        logic one;
        logic zero;
        logic take;
        logic start;
        logic finish;
        logic full;
        mstate_t nxt;
        tdc_width_t sum;
        core_rst = RST_SYNC | m_soft;
        take = d_req.cyc & d_req.stb & ~m_ack;
        one = |m_sq;
        zero = ~&m_sq;
        nxt = m_state;
        case (m_state)
            M_IDLE: if (m_cfg.en && !m_cfg.en_arm && one) nxt = M_COUNT;
                    else if (m_cfg.en && m_cfg.en_arm && m_arm[1]) nxt = M_ARMED;
            M_ARMED: if (one) nxt = M_COUNT;
                     else if (!m_cfg.en) nxt = M_IDLE;
            default: if (zero || !m_cfg.en) nxt = M_IDLE;
        endcase
        start = (m_state != M_COUNT) && (nxt == M_COUNT);
        finish = (m_state == M_COUNT) && (nxt == M_IDLE);
        sum = m_width + tdc_width_t'(count_ones(m_sq));
        if (core_rst) begin
            m_sq = '0;
            m_arm = '0;
            m_state = M_IDLE;
            m_width = '0;
            m_evt = '0;
            m_fifo.delete();
            m_lost = '0;
        end else begin
            full = (m_fifo.size() == FIFO_DEPTH);
            if (d_read && m_fifo.size() > 0) void'(m_fifo.pop_front());
            if (finish && !full) m_fifo.push_back({4'b0100, m_evt, sum});
            else if (finish && m_lost != 8'hff) m_lost++;   // Saturating
            if (finish) m_evt++;
            m_width = start ? tdc_width_t'(count_ones(m_sq)) : sum;
            m_sq = d_sample;
            m_arm = {m_arm[0], d_arm};
            m_state = nxt;
        end
        if (RST_SYNC) begin
            m_ack = 1'b0;
            m_soft = 1'b0;
            m_cfg = '0;
        end else begin
            m_ack = take;
            m_soft = take & d_req.we & (d_req.adr == REG_SOFT_RST);
            if (take && d_req.we && d_req.adr == REG_SOFT_RST) m_cfg = '0;
            if (take && d_req.we && d_req.adr == REG_CONFIG) m_cfg = d_req.dat[1:0];
        end
    endtask

    // One clock edge with model update, drive and a mid-cycle tdc_out check
    task automatic tick();
        @(posedge CLK40);
        model_edge();
        sample <= n_sample;
        arm_tdc <= n_arm;
        fifo_read <= n_read;
        wb_i <= n_req;
        d_sample = n_sample;
        d_arm = n_arm;
        d_read = n_read;
        d_req = n_req;
        @(negedge CLK40);
        check_flag("tdc_out", tdc_out, |m_sq);
    endtask

    task automatic bus_access(logic we, wb_adr_t adr, wb_dat_t dat, output wb_dat_t rdat);
        int waited;
        n_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        tick();
        waited = 0;
        do begin
            tick();
            waited++;
        end while (!wb_o.ack && waited < 4);
        if (!wb_o.ack) report_failure("No ack on bus request within 4 cycles");
        if (waited != 1) report_failure("Bus ack came later than one cycle");
        rdat = wb_o.dat;
        n_req = '0;
        tick();
        check_flag("wb_o.ack", wb_o.ack, 1'b0);
    endtask

    task automatic pop_record();
        int waited;
        waited = 0;
        while (fifo_empty && waited < 8) begin
            tick();
            waited++;
        end
        if (fifo_empty) report_failure("FIFO stayed empty while a record was expected");
        if (m_fifo.size() == 0) report_failure("FIFO holds a record the model never made");
        check_record("fifo_data", fifo_data, m_fifo[0]);
        n_read = 1'b1;
        tick();
        n_read = 1'b0;
        tick();
    endtask

    task automatic add(kind_t k, logic [31:0] op, logic [31:0] exp);
        steps.push_back('{kind: k, op: op, exp: exp});
    endtask

    task automatic add_pulse(sample_word_t w);
        add(K_WORD, w, 0);
        add(K_WORD, 0, 0);
    endtask

    task automatic build_table();
        add(K_READ, REG_LOST, 0);
        add(K_READ, REG_CONFIG, 0);
        add(K_WRITE, {REG_CONFIG, 8'h01}, 0);
        add(K_READ, REG_CONFIG, 1);
        add(K_WRITE, {REG_CONFIG, 8'h03}, 0);
        add(K_READ, REG_CONFIG, 3);
        add(K_WRITE, {REG_CONFIG, 8'h01}, 0);
        add_pulse(16'h0ff0);              // Inside one word
        add(K_WORD, 16'h000f, 0);         // Spans four words
        add(K_WORD, 16'hffff, 0);
        add(K_WORD, 16'hffff, 0);
        add_pulse(16'hf000);
        repeat (8) add(K_WORD, 32'h1_0000, 0);
        repeat (3) add(K_WORD, 0, 0);
        add(K_POP, 2, 0);
        // Armed mode
        add(K_WRITE, {REG_CONFIG, 8'h03}, 0);
        add_pulse(16'h00f0);
        add_pulse(16'h0ff0);
        add(K_POP, 1, 0);
        add(K_ARM, 1, 0);
        repeat (3) add(K_WORD, 0, 0);
        add_pulse(16'h01f0);
        add(K_ARM, 0, 0);
        add(K_WORD, 0, 0);
        add(K_POP, 0, 0);
        add(K_POP, 1, 0);
        // Overflow
        add(K_WRITE, {REG_CONFIG, 8'h01}, 0);
        repeat (FIFO_DEPTH + 3) add_pulse(16'h0f00);
        repeat (2) add(K_WORD, 0, 0);
        repeat (FIFO_DEPTH) add(K_POP, 0, 0);
        add(K_POP, 1, 0);
        add(K_READ, REG_LOST, 3);
        // Soft reset
        add_pulse(16'h0ff0);
        add(K_WORD, 0, 0);
        add(K_WRITE, {REG_SOFT_RST, 8'h00}, 0);
        add(K_READ, REG_CONFIG, 0);
        add(K_READ, REG_LOST, 0);
        add(K_POP, 1, 0);
        add(K_WRITE, {REG_CONFIG, 8'h01}, 0);
        add_pulse(16'h00ff);
        add(K_WORD, 0, 0);
        add(K_POP, 0, 0);
        add(K_POP, 1, 0);
    endtask

    initial begin
        wb_dat_t rdat;
        sample = '0;
        arm_tdc = 1'b0;
        fifo_read = 1'b0;
        wb_i = '0;
        n_sample = '0;
        n_arm = 1'b0;
        n_read = 1'b0;
        n_req = '0;
        d_sample = '0;
        d_arm = 1'b0;
        d_read = 1'b0;
        d_req = '0;
        m_sq = '0;
        m_arm = '0;
        m_state = M_IDLE;
        m_width = '0;
        m_evt = '0;
        m_ack = 1'b0;
        m_soft = 1'b0;
        m_cfg = '0;
        m_lost = '0;
        build_table();
        @(negedge CLK40);
        while (RST_SYNC) tick();
        check_flag("fifo_empty", fifo_empty, 1'b1);
        foreach (steps[i]) begin
            case (steps[i].kind)
                K_WRITE: bus_access(1'b1, steps[i].op[9:8], steps[i].op[7:0], rdat);
                K_READ: begin
                    bus_access(1'b0, steps[i].op[1:0], 8'h00, rdat);
                    check_reg("wb_o.dat", rdat, steps[i].exp[7:0]);
                    if (steps[i].op[1:0] == REG_LOST)
                        check_reg("wb_o.dat lost count", rdat, m_lost);
                end
                K_WORD: begin
                    if (steps[i].op[16])
                        for (int b = 15; b >= 0; b--) n_sample[b] = lfsr_bit();
                    else
                        n_sample = steps[i].op[15:0];
                    tick();
                end
                K_ARM: begin
                    n_arm = steps[i].op[0];
                    tick();
                end
                default: begin
                    if (steps[i].op == 0) begin
                        pop_record();
                    end else begin
                        repeat (3) tick();
                        while (steps[i].op == 2 && m_fifo.size() > 0) pop_record();
                        repeat (2) tick();
                        check_flag("fifo_empty", fifo_empty, 1'b1);
                    end
                end
            endcase
        end
        $display("Simulation completed successfully");
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        #1;
        #(steps.size() * 10 * 4);
        $display("Watchdog expired before the table finished");
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- flist.f
hdl/tdc_pkg.sv
hdl/wb_pkg.sv
hdl/tdc_regs.sv
hdl/tdc_pulse_fsm.sv
hdl/tdc_width_accum.sv
hdl/tdc_event_fifo.sv
hdl/tdc_top.sv
tb/tb_clkgen.sv
tb/tb_tdc.sv
